// ==== include/pipeline_defines.svh ====
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

// Instruction address width
`define ADDR_W     32

// Register and datapath width
`define DATA_W     32

// General registers eax..edi
`define NUM_REGS   8
`define REG_IDX_W  3

// First fetch address after reset
`define RESET_PC   32'h0000_0000

`endif

// ==== verilog/pipeline_pkg.sv ====
`include "pipeline_defines.svh"

package pipeline_pkg;

   typedef logic [`REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`DATA_W-1:0]    word_t;

   // Opcode field, bits 31:28 of the instruction word
   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      OR   = 4'd4,
      XOR  = 4'd5,
      ADDI = 4'd6,
      MOVI = 4'd7,
      JMP  = 4'd8
   } op_e;

   typedef struct packed {
      logic [`ADDR_W-1:0] pc;
      word_t              instr;
   } fetch_pkt_t;

   typedef struct packed {
      logic [`ADDR_W-1:0] pc;
      op_e                op;
      reg_idx_t           rd;
      reg_idx_t           rs1;
      reg_idx_t           rs2;
      word_t              imm;       // Already extended
      logic               writes_rd;
      logic               uses_rs1;
      logic               uses_rs2;
   } dec_pkt_t;

   typedef struct packed {
      logic [`ADDR_W-1:0] pc;
      op_e                op;
      reg_idx_t           rd;
      logic               writes_rd;
      word_t              op_a;
      word_t              op_b;
      word_t              imm;
   } exe_pkt_t;

endpackage

// ==== verilog/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     flush,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     valid_q;
   payload_t data_q;

   // Refill in the same cycle the held item drains
   assign in_ready = !valid_q || out_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (flush) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready)
         data_q <= in_data;
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

   a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_data))
      else $error("pipe_stage payload changed while stalled");

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps
`include "pipeline_defines.svh"

module fetch_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     redirect,
   input  logic [`ADDR_W-1:0]       redirect_pc,
   output logic                     imem_valid,
   input  logic                     imem_ready,
   output logic [`ADDR_W-1:0]       imem_address,
   input  logic                     imem_dp_valid,
   output logic                     imem_dp_ready,
   input  logic [`DATA_W-1:0]       imem_dp_read_data,
   output logic                     f_valid,
   input  logic                     f_ready,
   output pipeline_pkg::fetch_pkt_t f_pkt
);
   import pipeline_pkg::*;

   logic [`ADDR_W-1:0] pc_q;        // Next address to request
   logic [`ADDR_W-1:0] req_pc_q;    // Address on the bus or awaiting data
   logic               req_valid_q;
   logic               wait_q;      // Request accepted, data pending
   logic               discard_q;
   logic               idle;
   logic               req_xfer;
   logic               resp_xfer;
   logic [`ADDR_W-1:0] launch_pc;
   logic               st_in_ready;
   fetch_pkt_t         st_in_data;

   assign idle      = !req_valid_q && !wait_q;
   assign req_xfer  = req_valid_q && imem_ready;
   assign resp_xfer = imem_dp_valid && imem_dp_ready;
   assign launch_pc = redirect ? redirect_pc : pc_q;

   assign imem_valid    = req_valid_q;
   assign imem_address  = req_pc_q;
   assign imem_dp_ready = wait_q && (st_in_ready || discard_q); // Stale data always drains

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q        <= `RESET_PC;
         req_pc_q    <= `RESET_PC;
         req_valid_q <= 1'b0;
         wait_q      <= 1'b0;
         discard_q   <= 1'b0;
      end else begin
         if (idle) begin
            req_valid_q <= 1'b1;
            req_pc_q    <= launch_pc;
            pc_q        <= launch_pc + `ADDR_W'(4);
         end else if (redirect) begin
            pc_q <= redirect_pc;
         end
         if (req_xfer) begin
            req_valid_q <= 1'b0;
            wait_q      <= 1'b1;
         end
         if (resp_xfer) begin
            wait_q    <= 1'b0;
            discard_q <= 1'b0;
         end
         // Request already in flight belongs to the old path
         if (redirect && (req_valid_q || (wait_q && !resp_xfer)))
            discard_q <= 1'b1;
      end
   end

   assign st_in_data.pc    = req_pc_q;
   assign st_in_data.instr = imem_dp_read_data;

   pipe_stage #(.payload_t(fetch_pkt_t)) fetch_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (redirect),
      .in_valid  (imem_dp_valid && wait_q && !discard_q),
      .in_ready  (st_in_ready),
      .in_data   (st_in_data),
      .out_valid (f_valid),
      .out_ready (f_ready),
      .out_data  (f_pkt)
   );

   a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
      imem_valid && !imem_ready |=> imem_valid && $stable(imem_address))
      else $error("imem request withdrawn before imem_ready");

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     f_valid,
   output logic                     f_ready,
   input  pipeline_pkg::fetch_pkt_t f_pkt,
   output logic                     d_valid,
   input  logic                     d_ready,
   output pipeline_pkg::dec_pkt_t   d_pkt
);
   import pipeline_pkg::*;

   logic [3:0] opc;
   logic [15:0] imm16;
   op_e        op;
   dec_pkt_t   dec;

   assign opc   = f_pkt.instr[31:28];
   assign imm16 = f_pkt.instr[15:0];

   // Undefined opcodes behave as NOP
   always_comb begin
      if (opc > JMP)
         op = NOP;
      else
         op = op_e'(opc);
   end

   always_comb begin
      dec.pc        = f_pkt.pc;
      dec.op        = op;
      dec.rd        = f_pkt.instr[26:24];
      dec.rs1       = f_pkt.instr[22:20];
      dec.rs2       = f_pkt.instr[18:16];
      dec.imm       = {16'h0000, imm16};
      dec.writes_rd = 1'b0;
      dec.uses_rs1  = 1'b0;
      dec.uses_rs2  = 1'b0;
      case (op)
         ADD, SUB, AND, OR, XOR: begin
            dec.writes_rd = 1'b1;
            dec.uses_rs1  = 1'b1;
            dec.uses_rs2  = 1'b1;
         end
         ADDI: begin
            dec.writes_rd = 1'b1;
            dec.uses_rs1  = 1'b1;
            dec.imm       = {{16{imm16[15]}}, imm16}; // Sign extended
         end
         MOVI: dec.writes_rd = 1'b1;
         default: ;  // JMP and NOP write nothing
      endcase
   end

   pipe_stage #(.payload_t(dec_pkt_t)) dec_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (f_valid),
      .in_ready  (f_ready),
      .in_data   (dec),
      .out_valid (d_valid),
      .out_ready (d_ready),
      .out_data  (d_pkt)
   );

endmodule

// ==== verilog/register_access.sv ====
`timescale 1ns/1ps
`include "pipeline_defines.svh"

module register_access (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  logic                   d_valid,
   output logic                   d_ready,
   input  pipeline_pkg::dec_pkt_t d_pkt,
   output logic                   r_valid,
   input  logic                   r_ready,
   output pipeline_pkg::exe_pkt_t r_pkt,
   input  logic                   wb_valid,
   input  pipeline_pkg::reg_idx_t wb_reg,
   input  pipeline_pkg::word_t    wb_data
);
   import pipeline_pkg::*;

   word_t                regs [`NUM_REGS];
   logic [`NUM_REGS-1:0] busy_q;
   logic [`NUM_REGS-1:0] wb_clear;
   logic [`NUM_REGS-1:0] busy_now;
   logic [`NUM_REGS-1:0] issue_set;
   logic                 hazard;
   logic                 issue;
   logic                 st_in_ready;
   exe_pkt_t             exe;

   // Writeback this cycle releases its register for issue
   assign wb_clear = wb_valid ? (`NUM_REGS'(1) << wb_reg) : '0;
   assign busy_now = busy_q & ~wb_clear;

   assign hazard = (d_pkt.uses_rs1  && busy_now[d_pkt.rs1]) ||
                   (d_pkt.uses_rs2  && busy_now[d_pkt.rs2]) ||
                   (d_pkt.writes_rd && busy_now[d_pkt.rd]);

   assign d_ready   = st_in_ready && !hazard && !flush;
   assign issue     = d_valid && d_ready;
   assign issue_set = (issue && d_pkt.writes_rd) ? (`NUM_REGS'(1) << d_pkt.rd) : '0;

   always_ff @(posedge clk) begin
      if (!rst_n)
         busy_q <= '0;
      else
         busy_q <= busy_now | issue_set;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wb_valid) begin
         regs[wb_reg] <= wb_data;
      end
   end

   always_comb begin
      exe.pc        = d_pkt.pc;
      exe.op        = d_pkt.op;
      exe.rd        = d_pkt.rd;
      exe.writes_rd = d_pkt.writes_rd;
      exe.imm       = d_pkt.imm;
      exe.op_a      = (wb_valid && wb_reg == d_pkt.rs1) ? wb_data : regs[d_pkt.rs1]; // Bypass
      exe.op_b      = (wb_valid && wb_reg == d_pkt.rs2) ? wb_data : regs[d_pkt.rs2];
   end

   pipe_stage #(.payload_t(exe_pkt_t)) reg_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (d_valid && !hazard && !flush),
      .in_ready  (st_in_ready),
      .in_data   (exe),
      .out_valid (r_valid),
      .out_ready (r_ready),
      .out_data  (r_pkt)
   );

   a_wb_busy : assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> busy_q[wb_reg])
      else $error("writeback to register with clear busy bit");

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps
`include "pipeline_defines.svh"

module execute_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   r_valid,
   output logic                   r_ready,
   input  pipeline_pkg::exe_pkt_t r_pkt,
   output logic                   redirect,
   output logic [`ADDR_W-1:0]     redirect_pc,
   output logic                   wb_valid,
   output pipeline_pkg::reg_idx_t wb_reg,
   output pipeline_pkg::word_t    wb_data,
   output logic [`ADDR_W-1:0]     retire_pc
);
   import pipeline_pkg::*;

   word_t result;

   assign r_ready = 1'b1;  // Single cycle, never stalls

   always_comb begin
      case (r_pkt.op)
         ADD:     result = r_pkt.op_a + r_pkt.op_b;
         SUB:     result = r_pkt.op_a - r_pkt.op_b;
         AND:     result = r_pkt.op_a & r_pkt.op_b;
         OR:      result = r_pkt.op_a | r_pkt.op_b;
         XOR:     result = r_pkt.op_a ^ r_pkt.op_b;
         ADDI:    result = r_pkt.op_a + r_pkt.imm;
         MOVI:    result = r_pkt.imm;
         default: result = '0;
      endcase
   end

   // Absolute target, taken as the jump is accepted
   assign redirect    = r_valid && (r_pkt.op == JMP);
   assign redirect_pc = r_pkt.imm[`ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n)
         wb_valid <= 1'b0;
      else
         wb_valid <= r_valid && r_ready && r_pkt.writes_rd;
   end

   always_ff @(posedge clk) begin
      if (r_valid) begin
         wb_reg    <= r_pkt.rd;
         wb_data   <= result;
         retire_pc <= r_pkt.pc;
      end
   end

endmodule

// ==== verilog/top_pipeline.sv ====
`timescale 1ns/1ps
`include "pipeline_defines.svh"

module top_pipeline (
   input  logic                  clk,
   input  logic                  rst_n,

   output logic                  imem_valid,
   input  logic                  imem_ready,
   output logic [`ADDR_W-1:0]    imem_address,
   input  logic                  imem_dp_valid,
   output logic                  imem_dp_ready,
   input  logic [`DATA_W-1:0]    imem_dp_read_data,

   output logic                  retire_valid,
   output logic [`ADDR_W-1:0]    retire_pc,
   output logic [`REG_IDX_W-1:0] retire_reg,
   output logic [`DATA_W-1:0]    retire_data
);
   import pipeline_pkg::*;

   // Stage channels
   logic               f_valid;
   logic               f_ready;
   fetch_pkt_t         f_pkt;
   logic               d_valid;
   logic               d_ready;
   dec_pkt_t           d_pkt;
   logic               r_valid;
   logic               r_ready;
   exe_pkt_t           r_pkt;

   logic               redirect;    // Also the flush of the younger stages
   logic [`ADDR_W-1:0] redirect_pc;

   logic               wb_valid;
   reg_idx_t           wb_reg;
   word_t              wb_data;

   fetch_unit uut_fetch (
      .clk               (clk),
      .rst_n             (rst_n),
      .redirect          (redirect),
      .redirect_pc       (redirect_pc),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .f_valid           (f_valid),
      .f_ready           (f_ready),
      .f_pkt             (f_pkt)
   );

   decode_unit uut_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (redirect),
      .f_valid (f_valid),
      .f_ready (f_ready),
      .f_pkt   (f_pkt),
      .d_valid (d_valid),
      .d_ready (d_ready),
      .d_pkt   (d_pkt)
   );

   register_access uut_register_access (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (redirect),
      .d_valid  (d_valid),
      .d_ready  (d_ready),
      .d_pkt    (d_pkt),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r_pkt    (r_pkt),
      .wb_valid (wb_valid),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data)
   );

   execute_unit uut_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .r_pkt       (r_pkt),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .wb_valid    (wb_valid),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .retire_pc   (retire_pc)
   );

   assign retire_valid = wb_valid;
   assign retire_reg   = wb_reg;
   assign retire_data  = wb_data;

endmodule

// ==== test/imem_model.sv ====
`timescale 1ns/1ps

module imem_model #(
   parameter int          MEM_WORDS = 256,
   parameter logic [31:0] SEED      = 32'd1
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        imem_valid,
   output logic        imem_ready,
   input  logic [31:0] imem_address,
   output logic        imem_dp_valid,
   input  logic        imem_dp_ready,
   output logic [31:0] imem_dp_read_data
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] resp_data [$];   // In request order
   int          resp_wait [$];
   logic        valid_seen;      // DUT outputs as they stood at the last rising edge
   logic        dp_ready_seen;
   logic [31:0] addr_seen;
   int          ready_wait;

   // Undefined opcode F, so untouched words retire nothing
   function automatic logic [31:0] fill_word(logic [31:0] addr);
      return {4'hF, addr[27:0] ^ {24'h0, addr[31:28]}};
   endfunction

   function automatic logic [31:0] read_word(logic [31:0] addr);
      if (addr < 32'(MEM_WORDS * 4))
         return mem[addr[IDX_W+1:2]];
      return fill_word(addr);
   endfunction

   task automatic clear_memory();
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = fill_word(32'(i * 4));
   endtask

   task automatic load_word(logic [31:0] addr, logic [31:0] data);
      mem[addr[IDX_W+1:2]] = data;
   endtask

   initial begin
      void'($urandom(SEED));
      imem_ready        = 1'b0;
      imem_dp_valid     = 1'b0;
      imem_dp_read_data = '0;
      valid_seen        = 1'b0;
      dp_ready_seen     = 1'b0;
      addr_seen         = '0;
      ready_wait        = -1;
      forever begin
         @(negedge clk);
         if (!rst_n) begin
            imem_ready    = 1'b0;
            imem_dp_valid = 1'b0;
            ready_wait    = -1;
            resp_data.delete();
            resp_wait.delete();
         end else begin
            if (imem_dp_valid && dp_ready_seen) begin  // Response taken
               void'(resp_data.pop_front());
               void'(resp_wait.pop_front());
               imem_dp_valid = 1'b0;
            end
            if (imem_ready && valid_seen) begin        // Request taken
               resp_data.push_back(read_word(addr_seen));
               resp_wait.push_back(int'($urandom_range(3, 1)));
               imem_ready = 1'b0;
               ready_wait = -1;
            end
            if (imem_valid && !imem_ready) begin
               if (ready_wait < 0)
                  ready_wait = int'($urandom_range(3, 0));
               if (ready_wait == 0)
                  imem_ready = 1'b1;
               else
                  ready_wait = ready_wait - 1;
            end
            if (!imem_dp_valid && resp_wait.size() > 0) begin
               resp_wait[0] = resp_wait[0] - 1;
               if (resp_wait[0] <= 0) begin
                  imem_dp_valid     = 1'b1;
                  imem_dp_read_data = resp_data[0];
               end
            end
         end
         valid_seen    = imem_valid;
         addr_seen     = imem_address;
         dp_ready_seen = imem_dp_ready;
      end
   end

endmodule

// ==== test/tb_top_pipeline.sv ====
`timescale 1ns/1ps
`include "pipeline_defines.svh"

module tb_top_pipeline;

   localparam int          IMEM_WORDS   = 256;
   localparam logic [31:0] SEED         = 32'hc2db_7d84;
   localparam int          TAIL_CYCLES  = 20;   // Quiet period after the last retire
   localparam string       PATTERN_FILE = "test/program_patterns.txt";

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  imem_valid;
   logic                  imem_ready;
   logic [`ADDR_W-1:0]    imem_address;
   logic                  imem_dp_valid;
   logic                  imem_dp_ready;
   logic [`DATA_W-1:0]    imem_dp_read_data;
   logic                  retire_valid;
   logic [`ADDR_W-1:0]    retire_pc;
   logic [`REG_IDX_W-1:0] retire_reg;
   logic [`DATA_W-1:0]    retire_data;

   logic [31:0] exp_pc [$];
   logic [31:0] exp_reg [$];
   logic [31:0] exp_data [$];
   int          retired;
   int          limit_cycles;

   always #5 clk = ~clk;

   top_pipeline uut (
      .clk               (clk),
      .rst_n             (rst_n),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .retire_valid      (retire_valid),
      .retire_pc         (retire_pc),
      .retire_reg        (retire_reg),
      .retire_data       (retire_data)
   );

   imem_model #(.MEM_WORDS(IMEM_WORDS), .SEED(SEED)) imem (
      .clk               (clk),
      .rst_n             (rst_n),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data)
   );

   task automatic abort_run(string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected)
         abort_run($sformatf("ERROR %s expected=0x%08h actual=0x%08h", name, expected, actual));
   endtask

   task automatic check_retire();
      string tag;
      tag = $sformatf("retire %0d", retired);
      check_value({tag, " pc"}, exp_pc[retired], retire_pc);
      check_value({tag, " reg"}, exp_reg[retired], 32'(retire_reg));
      check_value({tag, " data"}, exp_data[retired], retire_data);
      retired++;
   endtask

   // P lines go to memory, E lines to the expected retire queues
   task automatic load_patterns();
      int          fd;
      int          code;
      int          fields;
      int          line_no;
      string       line;
      byte         kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         abort_run({"Cannot open the pattern file ", PATTERN_FILE});
      end else begin
         imem.clear_memory();
         line_no = 1;
         code = $fgets(line, fd);
         while (code != 0) begin
            kind = line.getc(0);
            if (kind == "P") begin
               fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
               if (fields != 2 || a[1:0] != 2'b00 || a >= 32'(IMEM_WORDS * 4))
                  abort_run($sformatf("Bad program line %0d in the pattern file", line_no));
               else
                  imem.load_word(a, b);
            end else if (kind == "E") begin
               fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
               if (fields != 3) begin
                  abort_run($sformatf("Bad expected line %0d in the pattern file", line_no));
               end else begin
                  exp_pc.push_back(a);
                  exp_reg.push_back(b);
                  exp_data.push_back(c);
               end
            end else if (kind != "#" && kind != " " && kind != "\n" && kind != "\r") begin
               abort_run($sformatf("Unknown line %0d in the pattern file", line_no));
            end
            line_no++;
            code = $fgets(line, fd);
         end
         $fclose(fd);
         if (exp_pc.size() == 0)
            abort_run("The pattern file holds no expected retires");
      end
   endtask

   initial begin : main
      logic first_req;
      rst_n     = 1'b0;
      first_req = 1'b0;
      load_patterns();
      limit_cycles = 100 + 40 * exp_pc.size();
      repeat (3) begin
         @(negedge clk);
         check_value("reset imem_valid", 32'd0, 32'(imem_valid));
         check_value("reset retire_valid", 32'd0, 32'(retire_valid));
      end
      rst_n = 1'b1;
      while (retired < exp_pc.size()) begin
         @(negedge clk);
         if (!first_req && imem_valid) begin
            check_value("first request address", `RESET_PC, imem_address);
            first_req = 1'b1;
         end
         if (retire_valid)
            check_retire();
      end
      // Program ends in a jump to itself
      repeat (TAIL_CYCLES) begin
         @(negedge clk);
         check_value("no retire after program end", 32'd0, 32'(retire_valid));
      end
      $display("TB PASSED");
      $finish;
   end

   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      abort_run($sformatf("Timeout after %0d cycles, retires stopped coming at %0d of %0d",
                          limit_cycles, retired, exp_pc.size()));
   end

endmodule

// ==== test/program_patterns.txt ====
# P <byte address> <instruction word>      program memory contents, hex
# E <pc> <register> <data>                 expected retires in program order, hex
P 00000000 70001234   movi eax, 0x1234
P 00000004 7100F00F   movi ecx, 0xf00f
P 00000008 6200FFFF   addi edx, eax, -1
P 0000000C 63108000   addi ebx, ecx, -32768
P 00000010 14010000   add  esp, eax, ecx
P 00000014 25420000   sub  ebp, esp, edx
P 00000018 36510000   and  esi, ebp, ecx
P 0000001C 47630000   or   edi, esi, ebx
P 00000020 50750000   xor  eax, edi, ebp
P 00000024 21040000   sub  ecx, eax, esp
P 00000028 00000000   nop
P 0000002C B2015678   undefined opcode with rd = edx
P 00000030 13220000   add  ebx, edx, edx
P 00000034 80000040   jmp  0x40
P 00000038 7400DEAD   movi esp, 0xdead    skipped
P 0000003C 65500001   addi ebp, ebp, 1    skipped
P 00000040 66100010   addi esi, ecx, 16
P 00000044 17450000   add  edi, esp, ebp
P 00000048 62207FFF   addi edx, edx, 0x7fff
P 0000004C 62207FFF   addi edx, edx, 0x7fff
P 00000050 80000058   jmp  0x58
P 00000054 7000BAD0   movi eax, 0xbad0    skipped
P 00000058 40030000   or   eax, eax, ebx
P 0000005C 8000005C   jmp  0x5c
E 00000000 0 00001234
E 00000004 1 0000F00F
E 00000008 2 00001233
E 0000000C 3 0000700F
E 00000010 4 00010243
E 00000014 5 0000F010
E 00000018 6 0000F000
E 0000001C 7 0000F00F
E 00000020 0 0000001F
E 00000024 1 FFFEFDDC
E 00000030 3 00002466
E 00000040 6 FFFEFDEC
E 00000044 7 0001F253
E 00000048 2 00009232
E 0000004C 2 00011231
E 00000058 0 0000247F

// ==== list.f ====
+incdir+include
verilog/pipeline_pkg.sv
verilog/pipe_stage.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/register_access.sv
verilog/execute_unit.sv
verilog/top_pipeline.sv
test/imem_model.sv
test/tb_top_pipeline.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_top_pipeline -f list.f -o tb_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
